//--- rtl/cpuPkg.sv
package cpuPkg;

        //////////////////////////////
        // sizes

        localparam int wordWidth    = 16;
        localparam int numRegs      = 8;
        localparam int dataMemWords = 256;
        localparam int memAddrWidth = $clog2(dataMemWords);   // word index bits
        localparam int pcStep       = 2;                       // pc counts bytes
        localparam int immShort     = 5;                       // addi, ld, st
        localparam int immLong      = 8;                       // lbi, beqz, bnez
        localparam int immJump      = 11;                      // j displacement

        typedef logic [wordWidth-1:0]        wordT;
        typedef logic [$clog2(numRegs)-1:0]  regIdxT;
        typedef logic [wordWidth-1:0]        instT;

        //////////////////////////////
        // encodings

        // instr[15:11]
        typedef enum logic [4:0] {
                opHalt  = 5'b00000,
                opNop   = 5'b00001,
                opJ     = 5'b00100,
                opAddi  = 5'b01000,
                opBeqz  = 5'b01100,
                opBnez  = 5'b01101,
                opSt    = 5'b10000,
                opLd    = 5'b10001,
                opLbi   = 5'b11000,
                opRType = 5'b11011   // add/sub/xor/and, func in instr[1:0]
        } opcodeT;

        // r-format function field, sub is rs - rt
        typedef enum logic [1:0] {
                opAdd = 2'b00,
                opSub = 2'b01,
                opXor = 2'b10,
                opAnd = 2'b11
        } funcT;

        typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluXor, aluPassB} aluOpT;

        typedef enum logic [1:0] {fwdNone, fwdExMem, fwdMemWb} fwdSelT;

        //////////////////////////////
        // pipeline registers

        typedef struct packed {
                logic  regWrite;
                logic  memRead;
                logic  memWrite;
                logic  memToReg;
                logic  aluSrc;        // imm into alu b
                logic  branch;
                logic  branchOnZero;  // beqz vs bnez
                logic  jump;
                logic  halt;          // also set for illegal
                logic  illegal;
                aluOpT aluOp;
        } ctrlT;

        typedef struct packed {
                logic valid;
                instT instr;
                wordT pcNext;
        } ifIdT;

        typedef struct packed {
                logic   valid;
                ctrlT   ctrl;
                wordT   pcNext;
                wordT   readA;
                wordT   readB;
                wordT   imm;
                regIdxT rs;
                regIdxT rt;
                regIdxT rd;
        } idExT;

        typedef struct packed {
                logic   valid;
                ctrlT   ctrl;
                wordT   aluResult;
                wordT   storeData;
                regIdxT rd;
        } exMemT;

        typedef struct packed {
                logic   valid;
                ctrlT   ctrl;
                wordT   aluResult;
                wordT   loadData;
                regIdxT rd;
        } memWbT;

        typedef struct packed {
                logic   valid;
                regIdxT rd;
                wordT   data;
        } retireT;

endpackage

//--- rtl/fetchStage.sv
module fetchStage (
        input  logic         clk,
        input  logic         rst,
        input  logic         stall,
        input  logic         freeze,
        input  logic         redirect,
        input  cpuPkg::wordT redirectPc,
        output cpuPkg::wordT pc,
        output cpuPkg::wordT pcNext
);
        import cpuPkg::*;

        assign pcNext = pc + wordT'(pcStep);   // sequential address, also link for targets

        // redirect beats freeze, a taken branch is older than a decoded halt
        always_ff @(posedge clk) begin
                if (rst) begin
                        pc <= '0;
                end else if (redirect) begin
                        pc <= redirectPc;
                end else if (!(stall || freeze)) begin
                        pc <= pcNext;
                end
        end

endmodule

//--- rtl/regFile.sv
module regFile (
        input  logic           clk,
        input  logic           rst,
        input  cpuPkg::regIdxT rdAddrA,
        input  cpuPkg::regIdxT rdAddrB,
        output cpuPkg::wordT   rdDataA,
        output cpuPkg::wordT   rdDataB,
        input  logic           wrEn,
        input  cpuPkg::regIdxT wrAddr,
        input  cpuPkg::wordT   wrData
);
        import cpuPkg::*;

        wordT regs [numRegs];

        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int i = 0; i < numRegs; i++) begin
                                regs[i] <= '0;
                        end
                end else if (wrEn) begin
                        regs[wrAddr] <= wrData;
                end
        end

        // write-before-read, covers the wb to decode distance
        assign rdDataA = (wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
        assign rdDataB = (wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

//--- rtl/decodeStage.sv
module decodeStage (
        input  logic           clk,
        input  logic           rst,
        input  cpuPkg::ifIdT   ifId,
        input  logic           wbEn,
        input  cpuPkg::regIdxT wbRd,
        input  cpuPkg::wordT   wbData,
        output cpuPkg::idExT   idEx,
        output logic           haltSeen
);
        import cpuPkg::*;

        opcodeT opcode;
        funcT   func;
        ctrlT   ctrl;
        wordT   immS;
        wordT   immL;
        wordT   immJ;
        wordT   readA;
        wordT   readB;

        assign opcode = opcodeT'(ifId.instr[15:11]);
        assign func   = funcT'(ifId.instr[1:0]);

        // sign extension per format
        assign immS = {{(wordWidth-immShort){ifId.instr[immShort-1]}}, ifId.instr[immShort-1:0]};
        assign immL = {{(wordWidth-immLong){ifId.instr[immLong-1]}}, ifId.instr[immLong-1:0]};
        assign immJ = {{(wordWidth-immJump){ifId.instr[immJump-1]}}, ifId.instr[immJump-1:0]};

        regFile rf (
                .clk     (clk),
                .rst     (rst),
                .rdAddrA (ifId.instr[10:8]),
                .rdAddrB (ifId.instr[7:5]),
                .rdDataA (readA),
                .rdDataB (readB),
                .wrEn    (wbEn),
                .wrAddr  (wbRd),
                .wrData  (wbData)
        );

        //////////////////////////////
        // control decode

        always_comb begin
                ctrl = '0;
                case (opcode)
                        opRType: begin
                                ctrl.regWrite = 1'b1;
                                case (func)
                                        opAdd: ctrl.aluOp = aluAdd;
                                        opSub: ctrl.aluOp = aluSub;
                                        opXor: ctrl.aluOp = aluXor;
                                        opAnd: ctrl.aluOp = aluAnd;
                                endcase
                        end
                        opAddi: begin
                                ctrl.regWrite = 1'b1;
                                ctrl.aluSrc   = 1'b1;
                        end
                        opLbi: begin
                                ctrl.regWrite = 1'b1;
                                ctrl.aluSrc   = 1'b1;
                                ctrl.aluOp    = aluPassB;   // imm straight through
                        end
                        opLd: begin
                                ctrl.regWrite = 1'b1;
                                ctrl.aluSrc   = 1'b1;       // rs + imm5 address
                                ctrl.memRead  = 1'b1;
                                ctrl.memToReg = 1'b1;
                        end
                        opSt: begin
                                ctrl.aluSrc   = 1'b1;
                                ctrl.memWrite = 1'b1;       // data from rt field
                        end
                        opBeqz: begin
                                ctrl.branch       = 1'b1;
                                ctrl.branchOnZero = 1'b1;
                        end
                        opBnez:  ctrl.branch = 1'b1;
                        opJ:     ctrl.jump   = 1'b1;
                        opHalt:  ctrl.halt   = 1'b1;
                        opNop:   ctrl        = '0;
                        default: begin
                                ctrl.halt    = 1'b1;        // illegal stops like halt
                                ctrl.illegal = 1'b1;
                        end
                endcase
        end

        // next id/ex value
        always_comb begin
                idEx.valid  = ifId.valid;
                idEx.ctrl   = ctrl;
                idEx.pcNext = ifId.pcNext;
                idEx.readA  = readA;
                idEx.readB  = readB;
                idEx.rs     = ifId.instr[10:8];
                idEx.rt     = ifId.instr[7:5];
                case (opcode)
                        opLbi, opBeqz, opBnez: idEx.imm = immL;
                        opJ:                   idEx.imm = immJ;
                        default:               idEx.imm = immS;
                endcase
                case (opcode)
                        opRType: idEx.rd = ifId.instr[4:2];
                        opLbi:   idEx.rd = ifId.instr[10:8];  // lbi writes its rs slot
                        default: idEx.rd = ifId.instr[7:5];
                endcase
        end

        assign haltSeen = ifId.valid && ctrl.halt;

endmodule

//--- rtl/hazardUnit.sv
module hazardUnit (
        input  cpuPkg::ifIdT   ifId,
        input  cpuPkg::idExT   idEx,
        input  cpuPkg::exMemT  exMem,
        input  cpuPkg::memWbT  memWb,
        output logic           stall,
        output cpuPkg::fwdSelT fwdA,
        output cpuPkg::fwdSelT fwdB
);
        import cpuPkg::*;

        opcodeT ifOp;
        regIdxT ifRs;
        regIdxT ifRt;
        logic   usesRs;
        logic   usesRt;

        // nearest writer wins
        function automatic fwdSelT pickSrc(exMemT em, memWbT mw, regIdxT src);
                if (em.valid && em.ctrl.regWrite && em.rd == src) begin
                        return fwdExMem;
                end
                if (mw.valid && mw.ctrl.regWrite && mw.rd == src) begin
                        return fwdMemWb;
                end
                return fwdNone;
        endfunction

        assign ifOp = opcodeT'(ifId.instr[15:11]);
        assign ifRs = ifId.instr[10:8];
        assign ifRt = ifId.instr[7:5];

        //////////////////////////////
        // load-use

        // which source fields the decoding instruction really reads
        assign usesRs = ifOp inside {opRType, opAddi, opLd, opSt, opBeqz, opBnez};
        assign usesRt = ifOp inside {opRType, opSt};

        assign stall = ifId.valid && idEx.valid && idEx.ctrl.memRead &&
                       ((usesRs && idEx.rd == ifRs) || (usesRt && idEx.rd == ifRt));

        assign fwdA = pickSrc(exMem, memWb, idEx.rs);
        assign fwdB = pickSrc(exMem, memWb, idEx.rt);

endmodule

//--- rtl/executeStage.sv
module executeStage (
        input  cpuPkg::idExT   idEx,
        input  cpuPkg::fwdSelT fwdA,
        input  cpuPkg::fwdSelT fwdB,
        input  cpuPkg::wordT   exMemResult,
        input  cpuPkg::wordT   wbData,
        output cpuPkg::exMemT  exMem,
        output logic           redirect,
        output cpuPkg::wordT   redirectPc
);
        import cpuPkg::*;

        wordT opA;
        wordT opB;
        wordT aluB;
        wordT aluOut;
        logic taken;

        function automatic wordT fwdMux(fwdSelT sel, wordT regVal, wordT exVal, wordT wbVal);
                case (sel)
                        fwdExMem: return exVal;
                        fwdMemWb: return wbVal;
                        default:  return regVal;
                endcase
        endfunction

        assign opA  = fwdMux(fwdA, idEx.readA, exMemResult, wbData);
        assign opB  = fwdMux(fwdB, idEx.readB, exMemResult, wbData);
        assign aluB = idEx.ctrl.aluSrc ? idEx.imm : opB;

        //////////////////////////////
        // alu

        always_comb begin
                case (idEx.ctrl.aluOp)
                        aluAdd:   aluOut = opA + aluB;
                        aluSub:   aluOut = opA - aluB;
                        aluAnd:   aluOut = opA & aluB;
                        aluXor:   aluOut = opA ^ aluB;
                        aluPassB: aluOut = aluB;
                        default:  aluOut = opA + aluB;
                endcase
        end

        // beqz / bnez test forwarded rs
        assign taken      = idEx.ctrl.branch && (idEx.ctrl.branchOnZero == (opA == '0));
        assign redirect   = idEx.valid && (idEx.ctrl.jump || taken);
        assign redirectPc = idEx.pcNext + idEx.imm;   // pc-relative to next instr

        always_comb begin
                exMem.valid     = idEx.valid;
                exMem.ctrl      = idEx.ctrl;
                exMem.aluResult = aluOut;
                exMem.storeData = opB;   // st data, forwarded
                exMem.rd        = idEx.rd;
        end

endmodule

//--- rtl/memoryStage.sv
module memoryStage (
        input  logic          clk,
        input  cpuPkg::exMemT exMem,
        output cpuPkg::memWbT memWb
);
        import cpuPkg::*;

        wordT                    mem [dataMemWords];
        logic [memAddrWidth-1:0] wordIdx;

        assign wordIdx = exMem.aluResult[memAddrWidth:1];   // byte addr to word

        // single cycle, write on the edge
        always_ff @(posedge clk) begin
                if (exMem.valid && exMem.ctrl.memWrite) begin
                        mem[wordIdx] <= exMem.storeData;
                end
        end

        always_comb begin
                memWb.valid     = exMem.valid;
                memWb.ctrl      = exMem.ctrl;
                memWb.aluResult = exMem.aluResult;
                memWb.loadData  = mem[wordIdx];   // async read
                memWb.rd        = exMem.rd;
        end

endmodule

//--- rtl/cpuCore.sv
module cpuCore (
        input  logic           clk,
        input  logic           rst,
        output cpuPkg::wordT   instAddr,
        input  cpuPkg::instT   inst,
        output cpuPkg::retireT retire,
        output logic           halted,
        output logic           err
);
        import cpuPkg::*;

        ifIdT   ifIdQ;
        idExT   idExD;
        idExT   idExQ;
        exMemT  exMemD;
        exMemT  exMemQ;
        memWbT  memWbD;
        memWbT  memWbQ;
        wordT   pcNext;
        wordT   redirectPc;
        wordT   wbData;
        fwdSelT fwdA;
        fwdSelT fwdB;
        logic   stall;
        logic   redirect;
        logic   haltSeen;
        logic   haltHold;     // halt past decode, pc stays put
        logic   freeze;
        logic   wbEn;
        logic   haltNow;
        logic   errNow;
        logic   haltSticky;
        logic   errSticky;

        assign freeze = haltSeen || haltHold;

        //////////////////////////////
        // stages

        fetchStage fetch (
                .clk        (clk),
                .rst        (rst),
                .stall      (stall),
                .freeze     (freeze),
                .redirect   (redirect),
                .redirectPc (redirectPc),
                .pc         (instAddr),
                .pcNext     (pcNext)
        );

        decodeStage decode (
                .clk      (clk),
                .rst      (rst),
                .ifId     (ifIdQ),
                .wbEn     (wbEn),
                .wbRd     (memWbQ.rd),
                .wbData   (wbData),
                .idEx     (idExD),
                .haltSeen (haltSeen)
        );

        hazardUnit hazard (
                .ifId  (ifIdQ),
                .idEx  (idExQ),
                .exMem (exMemQ),
                .memWb (memWbQ),
                .stall (stall),
                .fwdA  (fwdA),
                .fwdB  (fwdB)
        );

        executeStage execute (
                .idEx        (idExQ),
                .fwdA        (fwdA),
                .fwdB        (fwdB),
                .exMemResult (exMemQ.aluResult),
                .wbData      (wbData),
                .exMem       (exMemD),
                .redirect    (redirect),
                .redirectPc  (redirectPc)
        );

        memoryStage memory (
                .clk   (clk),
                .exMem (exMemQ),
                .memWb (memWbD)
        );

        //////////////////////////////
        // pipeline registers

        always_ff @(posedge clk) begin
                if (rst) begin
                        ifIdQ.valid  <= 1'b0;
                        idExQ.valid  <= 1'b0;
                        exMemQ.valid <= 1'b0;
                        memWbQ.valid <= 1'b0;
                end else begin
                        if (redirect || freeze) begin
                                ifIdQ.valid <= 1'b0;            // squash younger fetch
                        end else if (!stall) begin
                                ifIdQ <= '{valid: 1'b1, instr: inst, pcNext: pcNext};
                        end
                        idExQ <= idExD;
                        if (stall || redirect) begin
                                idExQ.valid <= 1'b0;            // bubble
                        end
                        exMemQ <= exMemD;
                        memWbQ <= memWbD;
                end
        end

        // halt and err state, held until reset
        always_ff @(posedge clk) begin
                if (rst) begin
                        haltHold   <= 1'b0;
                        haltSticky <= 1'b0;
                        errSticky  <= 1'b0;
                end else begin
                        if (haltSeen && !redirect) haltHold <= 1'b1;   // not if flushed
                        if (haltNow) haltSticky <= 1'b1;
                        if (errNow) errSticky <= 1'b1;
                end
        end

        //////////////////////////////
        // writeback

        assign wbData = memWbQ.ctrl.memToReg ? memWbQ.loadData : memWbQ.aluResult;
        assign wbEn   = memWbQ.valid && memWbQ.ctrl.regWrite;

        assign retire = '{valid: wbEn, rd: memWbQ.rd, data: wbData};

        assign haltNow = memWbQ.valid && memWbQ.ctrl.halt;
        assign errNow  = memWbQ.valid && memWbQ.ctrl.illegal;
        assign halted  = haltSticky || haltNow;   // rises as halt hits wb
        assign err     = errSticky || errNow;

endmodule

//--- dv/cpuCore_props.sv
module cpuCoreProps (
        input logic           clk,
        input logic           rst,
        input cpuPkg::wordT   instAddr,
        input cpuPkg::retireT retire,
        input logic           halted,
        input logic           err
);
        int fails = 0;   // failed assertion count

        //////////////////////////////
        // reset and latency

        resetQuiet: assert property (@(posedge clk)
                $past(rst) |-> !retire.valid && !halted && !err && instAddr == '0)
                else begin
                        $error("retire, halted, err or instAddr active in or right after reset");
                        fails++;
                end

        // pc 0 is fetched in the first cycle out of reset and nothing retires before it
        firstRetire: assert property (@(posedge clk) disable iff (rst)
                $fell(rst) |-> !retire.valid [*4] ##1 retire.valid)
                else begin
                        $error("first instruction did not retire exactly four cycles after its fetch");
                        fails++;
                end

        retireKnown: assert property (@(posedge clk) disable iff (rst)
                retire.valid |-> !$isunknown(retire))
                else begin
                        $error("retire carries unknown bits");
                        fails++;
                end

        //////////////////////////////
        // halt and err

        haltHolds: assert property (@(posedge clk) disable iff (rst)
                halted |=> halted && $stable(instAddr))
                else begin
                        $error("halted dropped or instAddr moved after halt");
                        fails++;
                end

        haltQuiet: assert property (@(posedge clk) disable iff (rst)
                halted |-> !retire.valid)
                else begin
                        $error("retire seen while halted");
                        fails++;
                end

        errWithHalt: assert property (@(posedge clk) disable iff (rst)
                err |-> halted ##1 err)
                else begin
                        $error("err without halted, or err dropped before reset");
                        fails++;
                end

        errRise: assert property (@(posedge clk) disable iff (rst)
                $rose(err) |-> $rose(halted))
                else begin
                        $error("err and halted did not rise together");
                        fails++;
                end

endmodule

bind cpuCore cpuCoreProps props (
        .clk      (clk),
        .rst      (rst),
        .instAddr (instAddr),
        .retire   (retire),
        .halted   (halted),
        .err      (err)
);

//--- dv/cpuCoreTb.sv
module cpuCoreTb;
        import cpuPkg::*;

        localparam int progDepth = 64;
        localparam int aluSteps  = 16;   // random dependent alu ops

        logic   clk = 1'b0;
        logic   rst = 1'b1;
        wordT   instAddr;
        instT   inst;
        retireT retire;
        logic   halted;
        logic   err;

        instT   progs [2][progDepth];    // main and illegal-op programs
        int     progLen [2];
        int     buildIdx;
        int     cur = 0;
        retireT expQ [$];
        retireT expHead;
        logic   expErr;
        int     errors = 0;
        int     cycles = 0;
        int     cycleLimit = 1000;
        int     seed = 32'h3072_83c2;

        cpuCore dut (
                .clk      (clk),
                .rst      (rst),
                .instAddr (instAddr),
                .inst     (inst),
                .retire   (retire),
                .halted   (halted),
                .err      (err)
        );

        always #50 clk = ~clk;

        assign inst = progs[cur][instAddr[6:1]];   // combinational fetch port

        //////////////////////////////
        // program builder

        function automatic instT rFormat(funcT f, regIdxT rd, regIdxT rs, regIdxT rt);
                return {opRType, rs, rt, rd, f};
        endfunction

        // rt is the target of addi / ld and the data of st
        function automatic instT iFormat(opcodeT op, regIdxT rs, regIdxT rt, logic [4:0] imm);
                return {op, rs, rt, imm};
        endfunction

        function automatic instT lFormat(opcodeT op, regIdxT rs, logic [7:0] imm);
                return {op, rs, imm};
        endfunction

        task automatic emit(instT w);
                progs[buildIdx][progLen[buildIdx]] = w;
                progLen[buildIdx]++;
        endtask

        task automatic buildMain();
                int     r;
                int     kind;
                regIdxT rd;
                regIdxT prev1;
                regIdxT prev2;
                prev1 = 3'd1;
                prev2 = 3'd2;
                emit(lFormat(opLbi, 3'd1, 8'd37));    // stall-free start
                emit(lFormat(opLbi, 3'd2, 8'hc4));
                for (int i = 0; i < aluSteps; i++) begin
                        r    = $random(seed);
                        kind = {r} % 6;
                        rd   = r[10:8];
                        case (kind)
                                0, 1, 2, 3: emit(rFormat(funcT'(kind[1:0]), rd, prev1, prev2));
                                4:          emit(iFormat(opAddi, prev1, rd, r[15:11]));
                                default:    emit(lFormat(opLbi, rd, r[23:16]));
                        endcase
                        prev2 = prev1;   // next op reads the last two results
                        prev1 = rd;
                end
                // store then load back and use at once
                emit(lFormat(opLbi, 3'd1, 8'd40));
                emit(lFormat(opLbi, 3'd2, 8'hb7));
                emit(iFormat(opSt, 3'd1, 3'd2, 5'd2));
                emit(iFormat(opLd, 3'd1, 3'd3, 5'd2));
                emit(rFormat(opAdd, 3'd4, 3'd3, 3'd1));   // load-use bubble
                emit(iFormat(opSt, 3'd1, 3'd4, 5'd4));
                emit(iFormat(opLd, 3'd1, 3'd5, 5'd4));
                emit(iFormat(opAddi, 3'd5, 3'd6, 5'h1f));
                // branches and jump
                emit(lFormat(opLbi, 3'd7, 8'd0));
                emit(lFormat(opBeqz, 3'd7, 8'd4));        // taken and skips two
                emit(lFormat(opLbi, 3'd6, 8'd1));
                emit(lFormat(opLbi, 3'd6, 8'd2));
                emit(lFormat(opBnez, 3'd7, 8'd2));        // not taken
                emit(lFormat(opLbi, 3'd6, 8'd3));
                emit(lFormat(opBnez, 3'd6, 8'd2));        // taken on a forwarded rs
                emit(lFormat(opLbi, 3'd0, 8'd9));
                emit(lFormat(opBeqz, 3'd6, 8'd2));
                emit({opJ, 11'd2});
                emit(lFormat(opLbi, 3'd0, 8'd10));
                emit(rFormat(opAdd, 3'd0, 3'd6, 3'd6));
                emit({opHalt, 11'd0});
                emit(lFormat(opLbi, 3'd1, 8'd1));         // behind the halt
        endtask

        task automatic buildIllegal();
                emit(lFormat(opLbi, 3'd1, 8'd7));
                emit(iFormat(opAddi, 3'd1, 3'd2, 5'd3));
                emit(rFormat(opXor, 3'd3, 3'd1, 3'd2));
                emit({5'b11111, 11'd0});                  // unused opcode
                emit(lFormat(opLbi, 3'd4, 8'd1));
                emit({opHalt, 11'd0});
        endtask

        //////////////////////////////
        // instruction-level model

        task automatic runModel(int p);
                wordT   regs [numRegs];
                wordT   dmem [dataMemWords];
                wordT   pc;
                wordT   a;
                wordT   b;
                wordT   addr;
                wordT   val;
                wordT   immL;
                instT   w;
                regIdxT rd;
                logic   wr;
                logic   done;
                expQ.delete();
                expErr = 1'b0;
                done   = 1'b0;
                pc     = '0;
                for (int i = 0; i < numRegs; i++) begin
                        regs[i] = '0;
                end
                for (int n = 0; n < 4 * progDepth && !done; n++) begin
                        w    = progs[p][pc[6:1]];
                        pc   = pc + wordT'(pcStep);
                        a    = regs[w[10:8]];
                        b    = regs[w[7:5]];
                        addr = a + {{11{w[4]}}, w[4:0]};
                        immL = {{8{w[7]}}, w[7:0]};
                        wr   = 1'b0;
                        rd   = w[7:5];
                        case (w[15:11])
                                opRType: begin
                                        wr = 1'b1;
                                        rd = w[4:2];
                                        case (w[1:0])
                                                2'b00: val = a + b;
                                                2'b01: val = a - b;
                                                2'b10: val = a ^ b;
                                                2'b11: val = a & b;
                                        endcase
                                end
                                opAddi: begin
                                        wr  = 1'b1;
                                        val = addr;
                                end
                                opLbi: begin
                                        wr  = 1'b1;
                                        rd  = w[10:8];
                                        val = immL;
                                end
                                opLd: begin
                                        wr  = 1'b1;
                                        val = dmem[addr[8:1]];
                                end
                                opSt:    dmem[addr[8:1]] = b;
                                opBeqz:  pc = (a == '0) ? pc + immL : pc;
                                opBnez:  pc = (a != '0) ? pc + immL : pc;
                                opJ:     pc = pc + {{5{w[10]}}, w[10:0]};
                                opNop:   ;
                                opHalt:  done = 1'b1;
                                default: begin
                                        expErr = 1'b1;
                                        done   = 1'b1;
                                end
                        endcase
                        if (wr) begin
                                regs[rd] = val;
                                expQ.push_back('{valid: 1'b1, rd: rd, data: val});
                        end
                end
        endtask

        //////////////////////////////
        // checking

        always @(negedge clk) begin
                if (!rst && retire.valid) begin
                        if (expQ.size() == 0) begin
                                $display("%0t: r%0d retired but the model has no write left",
                                         $time, retire.rd);
                                errors++;
                        end else begin
                                expHead = expQ.pop_front();
                                assert (retire.rd == expHead.rd && retire.data == expHead.data)
                                else begin
                                        $display("[ERROR] %0t retire expected r%0d=%h got r%0d=%h",
                                                 $time, expHead.rd, expHead.data,
                                                 retire.rd, retire.data);
                                        errors++;
                                end
                        end
                end
        end

        always @(posedge clk) begin
                cycles <= cycles + 1;
                if (cycles == cycleLimit) begin
                        $display("timeout: core did not halt within %0d cycles", cycleLimit);
                        $display("retire errors %0d, assertion failures %0d",
                                 errors, dut.props.fails);
                        $display("ERRORS FOUND");
                        $finish;
                end
        end

        task automatic runProgram(int p);
                cur <= p;
                runModel(p);
                rst <= 1'b1;
                repeat (5) @(posedge clk);
                rst <= 1'b0;
                wait (halted === 1'b1);
                repeat (4) @(posedge clk);   // halted held and pc frozen
                @(negedge clk);
                assert (expQ.size() == 0) else begin
                        $display("%0t: %0d modeled writes never retired", $time, expQ.size());
                        errors++;
                end
                assert (err == expErr) else begin
                        $display("[ERROR] %0t err expected %b got %b", $time, expErr, err);
                        errors++;
                end
                @(posedge clk);
        endtask

        initial begin
                for (int p = 0; p < 2; p++) begin
                        progLen[p] = 0;
                        for (int i = 0; i < progDepth; i++) begin
                                progs[p][i] = {opHalt, 11'd0};
                        end
                end
                buildIdx = 0;
                buildMain();
                buildIdx = 1;
                buildIllegal();
                cycleLimit = 4 * (progLen[0] + progLen[1]) + 50;
                runProgram(0);
                runProgram(1);
                $display("retire errors %0d, assertion failures %0d", errors, dut.props.fails);
                if (errors == 0 && dut.props.fails == 0) begin
                        $display("NO ERRORS");
                end else begin
                        $display("ERRORS FOUND");
                end
                $finish;
        end

endmodule

//--- build.f
rtl/cpuPkg.sv
rtl/fetchStage.sv
rtl/regFile.sv
rtl/decodeStage.sv
rtl/hazardUnit.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/cpuCore.sv
dv/cpuCore_props.sv
dv/cpuCoreTb.sv
